// File: bp_macros.svh
`ifndef BP_MACROS_SVH
`define BP_MACROS_SVH

// core widths
`define BP_XLEN         32          // pc and instruction width

// btb geometry, pc[5:2] picks the row and pc[31:6] is the tag
`define BP_BTB_ROWS     16          // direct mapped rows
`define BP_IDX_LO       2           // lowest index bit, word aligned pc
`define BP_IDX_W        4           // index bits, log2 of rows
`define BP_TAG_LO       6           // tag starts above the index field

// outstanding prediction queue
`define BP_TRK_DEPTH    4           // max branches in flight

// risc-v major opcodes seen by predecode
`define BP_OP_BRANCH    7'b1100011  // beq/bne/blt/bge/bltu/bgeu
`define BP_OP_JAL       7'b1101111  // unconditional pc relative jump

// saturating counter start value
`define BP_CTR_RESET    2'b10       // weakly taken

`endif

// File: bp_pkg.sv
`include "bp_macros.svh"

package bp_pkg;

    typedef logic [`BP_XLEN-1:0]            addr_t;     // pc or branch target
    typedef logic [`BP_XLEN-1:0]            instr_t;    // raw fetched word
    typedef logic [`BP_IDX_W-1:0]           btb_idx_t;  // btb row select
    typedef logic [`BP_XLEN-`BP_TAG_LO-1:0] btb_tag_t;  // upper pc bits
    typedef logic [1:0]                     ctr_t;      // 11 st, 10 wt, 01 wn, 00 sn

    // one btb row
    typedef struct packed {
        logic       valid;      // row takes part in lookup
        btb_tag_t   tag;        // pc bits above the index
        addr_t      target;     // taken destination
        ctr_t       ctr;        // direction counter
        logic       uncond;     // jal row, always taken
    } btb_entry_t;

    // fetch side prediction
    typedef struct packed {
        logic       taken;      // predicted redirect
        addr_t      target;     // next pc, pc+4 when not taken
    } predict_t;

    // record kept per outstanding branch
    typedef struct packed {
        addr_t      pc;         // branch pc, trains the btb later
        logic       uncond;     // fetched as jal
        predict_t   pred;       // what fetch was told
    } track_entry_t;

    // execute stage outcome
    typedef struct packed {
        logic       taken;      // branch went
        addr_t      target;     // computed destination
    } resolve_t;

    // one btb training write
    typedef struct packed {
        btb_idx_t   idx;        // row of the branch pc
        btb_tag_t   tag;        // tag of the branch pc
        addr_t      target;     // resolved destination
        logic       uncond;     // jal
        logic       taken;      // outcome
    } train_t;

endpackage

// File: branch_target_buffer.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

module branch_target_buffer #(
    parameter int RD_PORTS = 2                          // fetch lookup + training lookup
) (
    input  logic                clk,
    input  logic                rst,

    input  bp_pkg::btb_idx_t    rd_idx   [RD_PORTS],    // async read addresses
    output bp_pkg::btb_entry_t  rd_entry [RD_PORTS],    // rows seen this cycle

    input  logic                wr_en,                  // write strobe that lands at the edge
    input  bp_pkg::btb_idx_t    wr_idx,
    input  bp_pkg::btb_entry_t  wr_entry
);

    logic [`BP_BTB_ROWS-1:0]    valid_q;                // per row valid is the only state that resets
    bp_pkg::btb_entry_t         mem_q [`BP_BTB_ROWS];   // row payload

    // valid bits follow the write and clear on reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;                              // every row invalid
        end else if (wr_en) begin
            valid_q[wr_idx] <= wr_entry.valid;
        end
    end

    // payload array written like a plain ram
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_idx] <= wr_entry;                  // tag, target, ctr, uncond
        end
    end

    // combinational read ports take valid from the reset vector
    always_comb begin
        for (int p = 0; p < RD_PORTS; p++) begin
            rd_entry[p]       = mem_q[rd_idx[p]];
            rd_entry[p].valid = valid_q[rd_idx[p]];     // masks stale payload after reset
        end
    end

    // the predictor only ever allocates or refreshes rows
    a_wr_valid : assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> wr_entry.valid
    ) else $error("btb write of an invalid entry to row %0d", wr_idx);

endmodule

// File: dynamic_branch_predictor.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

module dynamic_branch_predictor (
    input  logic                clk,
    input  logic                rst,

    input  bp_pkg::addr_t       fetch_pc,
    input  bp_pkg::instr_t      fetch_instr,
    output bp_pkg::predict_t    prediction,         // same cycle as fetch
    output logic                fetch_is_branch,    // branch or jal
    output logic                fetch_uncond,       // jal only

    input  logic                train_valid,        // resolve strobe from tracker
    input  bp_pkg::train_t      train
);

    localparam bp_pkg::addr_t PC_STEP = bp_pkg::addr_t'(4);    // fall through distance

    logic [6:0]         opcode;                 // predecode field
    bp_pkg::btb_idx_t   rd_idx   [2];           // 0 fetch, 1 training
    bp_pkg::btb_entry_t rd_entry [2];
    bp_pkg::btb_tag_t   fetch_tag;
    logic               fetch_hit;              // row valid and tag equal
    logic               train_hit;              // training row already owned by this pc
    logic               train_alloc;            // taken or jal, row gets (re)written
    bp_pkg::ctr_t       base_ctr;               // counter before this outcome
    logic               wr_en;
    bp_pkg::btb_entry_t wr_entry;

    // saturating up/down step of the 2 bit counter
    function automatic bp_pkg::ctr_t ctr_step(input bp_pkg::ctr_t ctr, input logic up);
        bp_pkg::ctr_t nxt;
        nxt = ctr;
        if (up && (ctr != 2'b11)) begin
            nxt = ctr + 2'b01;                  // toward strongly taken
        end else if (!up && (ctr != 2'b00)) begin
            nxt = ctr - 2'b01;                  // toward strongly not taken
        end
        return nxt;
    endfunction

    // predecode
    assign opcode          = fetch_instr[6:0];
    assign fetch_uncond    = (opcode == `BP_OP_JAL);
    assign fetch_is_branch = (opcode == `BP_OP_BRANCH) || fetch_uncond;  // jalr not handled

    // fetch lookup
    assign rd_idx[0]  = fetch_pc[`BP_IDX_LO +: `BP_IDX_W];
    assign fetch_tag  = fetch_pc[`BP_XLEN-1:`BP_TAG_LO];
    assign fetch_hit  = rd_entry[0].valid && (rd_entry[0].tag == fetch_tag);

    always_comb begin
        prediction.taken  = fetch_is_branch && fetch_hit &&
                            (rd_entry[0].uncond || rd_entry[0].ctr[1]);   // jal or wt/st
        prediction.target = prediction.taken ? rd_entry[0].target : fetch_pc + PC_STEP;
    end

    // training lookup, second index path into the same rows
    assign rd_idx[1]   = train.idx;
    assign train_hit   = rd_entry[1].valid && (rd_entry[1].tag == train.tag);
    assign train_alloc = train.taken || train.uncond;
    assign base_ctr    = (train_alloc && !train_hit) ? `BP_CTR_RESET : rd_entry[1].ctr;

    // not taken on a miss leaves the row alone
    assign wr_en = train_valid && (train_alloc || train_hit);

    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = train.tag;
        wr_entry.target = train_alloc ? train.target : rd_entry[1].target;
        wr_entry.uncond = train_alloc ? train.uncond : rd_entry[1].uncond;
        // a fresh jal resolved not taken keeps the start value
        wr_entry.ctr    = (train.taken || train_hit) ? ctr_step(base_ctr, train.taken)
                                                     : base_ctr;
    end

    branch_target_buffer #(
        .RD_PORTS   (2)
    ) btb0 (
        .clk        (clk),
        .rst        (rst),
        .rd_idx     (rd_idx),
        .rd_entry   (rd_entry),
        .wr_en      (wr_en),
        .wr_idx     (train.idx),
        .wr_entry   (wr_entry)
    );

endmodule

// File: prediction_tracker.sv
`timescale 1ns/10ps
`include "bp_macros.svh"

module prediction_tracker (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    push,           // branch fetched this cycle
    input  bp_pkg::track_entry_t    push_entry,

    input  logic                    resolve_valid,  // outcome of the oldest branch
    input  bp_pkg::resolve_t        resolve,

    output logic                    train_valid,    // same cycle as resolve
    output bp_pkg::train_t          train,

    output logic                    mispredict,     // one cycle after resolve
    output bp_pkg::addr_t           redirect_pc,
    output logic                    trk_full
);

    localparam int PTR_W = $clog2(`BP_TRK_DEPTH);
    localparam int CNT_W = $clog2(`BP_TRK_DEPTH + 1);
    localparam bp_pkg::addr_t PC_STEP = bp_pkg::addr_t'(4);

    bp_pkg::track_entry_t   mem_q [`BP_TRK_DEPTH];  // queue storage
    logic [PTR_W-1:0]       head_q;                 // oldest record
    logic [PTR_W-1:0]       tail_q;                 // next free slot
    logic [CNT_W-1:0]       count_q;
    logic                   mispredict_q;
    bp_pkg::addr_t          redirect_q;

    bp_pkg::track_entry_t   head;
    bp_pkg::addr_t          actual_next;            // where execution really goes
    bp_pkg::addr_t          predicted_next;         // where fetch went
    logic                   miss;
    logic                   flush;                  // wrong path, drop everything younger

    assign head     = mem_q[head_q];
    assign trk_full = (count_q == CNT_W'(`BP_TRK_DEPTH));

    // compare head record against the outcome
    assign actual_next    = resolve.taken ? resolve.target : head.pc + PC_STEP;
    assign predicted_next = head.pred.taken ? head.pred.target : head.pc + PC_STEP;
    assign miss           = (actual_next != predicted_next);
    assign flush          = resolve_valid && miss;

    // training write built from the head and the outcome
    assign train_valid  = resolve_valid;
    assign train.idx    = head.pc[`BP_IDX_LO +: `BP_IDX_W];
    assign train.tag    = head.pc[`BP_XLEN-1:`BP_TAG_LO];
    assign train.target = resolve.target;
    assign train.uncond = head.uncond;
    assign train.taken  = resolve.taken;

    assign mispredict  = mispredict_q;
    assign redirect_pc = redirect_q;

    // pointers and count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            mispredict_q <= 1'b0;
        end else begin
            mispredict_q <= flush;                  // single cycle pulse
            if (flush) begin
                head_q  <= tail_q;                  // empty, a same cycle push is wrong path too
                count_q <= '0;
            end else begin
                if (push) begin
                    tail_q <= tail_q + 1'b1;        // depth is a power of two
                end
                if (resolve_valid) begin
                    head_q <= head_q + 1'b1;
                end
                count_q <= count_q + CNT_W'(push) - CNT_W'(resolve_valid);
            end
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[tail_q] <= push_entry;
        end
        if (flush) begin
            redirect_q <= actual_next;              // held until the next mispredict
        end
    end

    // fetch has to stall branches while the queue is full
    a_push_full : assert property (
        @(posedge clk) disable iff (rst)
        push |-> !trk_full
    ) else $error("branch fetched while tracker full");

    // execute resolves only what fetch predicted
    a_resolve_empty : assert property (
        @(posedge clk) disable iff (rst)
        resolve_valid |-> (count_q != '0)
    ) else $error("resolve with no outstanding branch");

endmodule

// File: branch_predict_unit.sv
`timescale 1ns/10ps

module branch_predict_unit (
    input  logic                clk,
    input  logic                rst,

    input  logic                fetch_valid,    // fetch_pc/fetch_instr meaningful
    input  bp_pkg::addr_t       fetch_pc,
    input  bp_pkg::instr_t      fetch_instr,
    output bp_pkg::predict_t    prediction,
    output logic                trk_full,       // no branch fetch while high

    input  logic                resolve_valid,
    input  bp_pkg::resolve_t    resolve,
    output logic                mispredict,
    output bp_pkg::addr_t       redirect_pc
);

    logic                   fetch_is_branch;
    logic                   fetch_uncond;
    logic                   push;               // record this prediction
    bp_pkg::track_entry_t   push_entry;
    logic                   train_valid;        // tracker to btb
    bp_pkg::train_t         train;

    assign push = fetch_valid && fetch_is_branch;

    always_comb begin
        push_entry.pc     = fetch_pc;
        push_entry.uncond = fetch_uncond;
        push_entry.pred   = prediction;         // remembered for the compare on resolve
    end

    dynamic_branch_predictor pred0 (
        .clk                (clk),
        .rst                (rst),
        .fetch_pc           (fetch_pc),
        .fetch_instr        (fetch_instr),
        .prediction         (prediction),
        .fetch_is_branch    (fetch_is_branch),
        .fetch_uncond       (fetch_uncond),
        .train_valid        (train_valid),
        .train              (train)
    );

    prediction_tracker trk0 (
        .clk                (clk),
        .rst                (rst),
        .push               (push),
        .push_entry         (push_entry),
        .resolve_valid      (resolve_valid),
        .resolve            (resolve),
        .train_valid        (train_valid),
        .train              (train),
        .mispredict         (mispredict),
        .redirect_pc        (redirect_pc),
        .trk_full           (trk_full)
    );

endmodule

// File: tb_branch_predict_unit.sv
`timescale 1ns/10ps

module tb_branch_predict_unit;

    localparam int MAX_EV    = 128;             // trace capacity
    localparam int CLK_NS    = 4;
    localparam int RST_CYC   = 16;
    localparam int EV_CYC    = 4;               // worst case cycles per trace event

    logic                   clk;
    logic                   rst;
    logic                   fetch_valid;
    bp_pkg::addr_t          fetch_pc;
    bp_pkg::instr_t         fetch_instr;
    bp_pkg::predict_t       prediction;
    logic                   trk_full;
    logic                   resolve_valid;
    bp_pkg::resolve_t       resolve;
    logic                   mispredict;
    bp_pkg::addr_t          redirect_pc;

    // trace storage, one slot per event line
    logic [8*24-1:0]        ev_name [MAX_EV];
    logic [7:0]             ev_kind [MAX_EV];   // F or R
    logic [31:0]            ev_a    [MAX_EV];
    logic [31:0]            ev_b    [MAX_EV];
    logic [31:0]            ev_c    [MAX_EV];
    logic [31:0]            ev_d    [MAX_EV];
    logic [31:0]            ev_e    [MAX_EV];
    int                     n_events = 0;
    bit                     trace_loaded = 1'b0;

    int                     errors = 0;         // mismatches over the whole run
    int                     checks = 0;
    int                     test_errors = 0;    // mismatches in the current test
    int                     tests_pass = 0;
    int                     tests_fail = 0;
    string                  cur_test = "";

    branch_predict_unit dut0 (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_instr    (fetch_instr),
        .prediction     (prediction),
        .trk_full       (trk_full),
        .resolve_valid  (resolve_valid),
        .resolve        (resolve),
        .mispredict     (mispredict),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // one compare, one report line on a mismatch
    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("mismatch %0s %0s: expected %h actual %h", test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // close the running test and print its line
    task automatic end_test();
        if (test_errors == 0) begin
            tests_pass++;
            $display("test %-14s passed", cur_test);
        end else begin
            tests_fail++;
            $display("test %-14s failed with %0d mismatches", cur_test, test_errors);
        end
        test_errors = 0;
    endtask

    // read bp_trace.txt, skipping comment and empty lines
    task automatic load_trace(output bit ok);
        int              fd;
        int              n;
        string           line;
        logic [8*24-1:0] name_v;
        logic [7:0]      kind_v;
        logic [31:0]     a, b, c, d, e;
        ok = 1'b1;
        fd = $fopen("bp_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file bp_trace.txt");
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;     // header or blank
            n = $sscanf(line, "%s %s %h %h %h %h %h", name_v, kind_v, a, b, c, d, e);
            if (n != 7 || n_events == MAX_EV || (kind_v != "F" && kind_v != "R")) begin
                $display("trace line could not be read: %0s", line);
                ok = 1'b0;
                continue;
            end
            ev_name[n_events] = name_v;
            ev_kind[n_events] = kind_v;
            ev_a[n_events]    = a;
            ev_b[n_events]    = b;
            ev_c[n_events]    = c;
            ev_d[n_events]    = d;
            ev_e[n_events]    = e;
            n_events++;
        end
        $fclose(fd);
    endtask

    // stimulus and checking
    initial begin
        bit    ok;
        int    gap;
        string name_s;
        rst           = 1'b1;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        fetch_instr   = '0;
        resolve_valid = 1'b0;
        resolve       = '0;
        void'($urandom(32'h0044ccce));          // fixed seed for the idle gaps
        load_trace(ok);
        if (!ok) errors++;
        trace_loaded = 1'b1;
        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < n_events; i++) begin
            name_s = $sformatf("%0s", ev_name[i]);
            if (i > 0 && name_s != cur_test) end_test();
            cur_test = name_s;
            @(negedge clk);
            if (ev_kind[i] == "F") begin
                fetch_valid = 1'b1;
                fetch_pc    = ev_a[i];
                fetch_instr = ev_b[i];
            end else begin
                resolve_valid  = 1'b1;
                resolve.taken  = ev_a[i][0];
                resolve.target = ev_b[i];
            end
            #1;                                 // prediction settles well before the edge
            if (ev_kind[i] == "F") begin
                check_value(name_s, "taken", ev_c[i], 32'(prediction.taken));
                check_value(name_s, "target", ev_d[i], prediction.target);
                check_value(name_s, "trk_full", ev_e[i], 32'(trk_full));
            end
            @(negedge clk);
            fetch_valid   = 1'b0;
            resolve_valid = 1'b0;
            #1;
            if (ev_kind[i] == "R") begin        // registered one cycle after resolve
                check_value(name_s, "mispredict", ev_c[i], 32'(mispredict));
                if (ev_c[i][0]) begin
                    check_value(name_s, "redirect_pc", ev_d[i], redirect_pc);
                end
            end
            gap = $urandom % 3;                 // 0 to 2 idle cycles
            repeat (gap) @(negedge clk);
        end
        if (n_events > 0) end_test();
        $display("tests %0d passed %0d failed, %0d checks, %0d mismatches",
                 tests_pass, tests_fail, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog sized from the trace length
    initial begin
        int wd_ns;
        wait (trace_loaded);
        wd_ns = (n_events * EV_CYC + RST_CYC + 8) * CLK_NS + 100;
        #(wd_ns);
        $display("timeout: the trace did not finish within %0d ns", wd_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: bp_trace.txt
# name kind a b c d e, all numbers hex
# F fetch:   a=pc b=instr c=expected taken d=expected target e=expected trk_full
# R resolve: a=taken b=target c=expected mispredict d=expected redirect_pc e=unused
after_reset F 00001008 00208463 0 0000100c 0
after_reset F 00001010 0080006f 0 00001014 0
after_reset R 1 00001100 1 00001100 0
counter_train F 00001008 00208463 1 00001100 0
counter_train R 1 00001100 0 00000000 0
counter_train F 00001008 00208463 1 00001100 0
counter_train R 0 00001100 1 0000100c 0
counter_train F 00001008 00208463 1 00001100 0
counter_train R 0 00001100 1 0000100c 0
counter_train F 00001008 00208463 0 0000100c 0
counter_train R 0 00001100 0 00000000 0
counter_train F 00001008 00208463 0 0000100c 0
counter_train R 0 00001100 0 00000000 0
counter_train F 00001008 00208463 0 0000100c 0
counter_train R 1 00001100 1 00001100 0
counter_train F 00001008 00208463 0 0000100c 0
counter_train R 1 00001100 1 00001100 0
counter_train F 00001008 00208463 1 00001100 0
counter_train R 1 00001100 0 00000000 0
jal_taken F 00001010 0080006f 0 00001014 0
jal_taken R 1 00001018 1 00001018 0
jal_taken F 00001010 0080006f 1 00001018 0
jal_taken R 0 00001018 1 00001014 0
jal_taken F 00001010 0080006f 1 00001018 0
jal_taken R 0 00001018 1 00001014 0
jal_taken F 00001010 0080006f 1 00001018 0
jal_taken R 1 00001018 0 00000000 0
alias_miss F 00002008 00208463 0 0000200c 0
alias_miss R 0 00002100 0 00000000 0
alias_miss F 00001008 00100093 0 0000100c 0
alias_miss F 00001008 00208463 1 00001100 0
alias_miss R 1 00001100 0 00000000 0
target_change F 00001008 00208463 1 00001100 0
target_change R 1 00001200 1 00001200 0
target_change F 00001008 00208463 1 00001200 0
target_change R 1 00001200 0 00000000 0
full_flush F 00003020 00208463 0 00003024 0
full_flush F 00003024 00208463 0 00003028 0
full_flush F 00003028 00208463 0 0000302c 0
full_flush F 0000302c 00208463 0 00003030 0
full_flush F 00003030 00100093 0 00003034 1
full_flush R 1 00003400 1 00003400 0
full_flush F 00003030 00208463 0 00003034 0
full_flush R 0 00003400 0 00000000 0

// File: tb.f
+incdir+.
bp_pkg.sv
branch_target_buffer.sv
dynamic_branch_predictor.sv
prediction_tracker.sv
branch_predict_unit.sv
tb_branch_predict_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the branch predictor testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_branch_predict_unit -o sim_bpu
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_bpu)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
